// ==== gb_video_pkg.sv ====
`default_nettype none

package gb_video_pkg;

  ////////////////////
  // LCD geometry
  ////////////////////
  localparam int gb_width  = 160;     // Pixels per LCD line
  localparam int gb_height = 144;     // LCD lines per frame
  localparam int fb_depth  = 23040;   // Shade buffer entries
  localparam int fb_addr_w = 15;

  ////////////////////
  // Output raster
  ////////////////////
  localparam int h_active     = 320;  // Twice the LCD width
  localparam int h_total      = 400;
  localparam int h_sync_start = 336;
  localparam int h_sync_len   = 32;
  localparam int v_active     = 288;  // Twice the LCD height
  localparam int v_total      = 312;
  localparam int v_sync_start = 295;
  localparam int v_sync_len   = 3;
  localparam int h_cnt_w      = 9;
  localparam int v_cnt_w      = 9;

  // Button filter length in cycles
  localparam int debounce_cycles = 16;

  // Raster counter to DVI pins
  localparam int mixer_latency = 3;

  // Palette select, stepped in this order
  typedef enum logic [1:0] {
    pal_gray,
    pal_green,
    pal_amber,
    pal_inverse
  } palette_t;

  // LCD capture FSM
  typedef enum logic [1:0] {
    cap_wait_frame,  // Until the first vsync
    cap_active,
    cap_frozen       // Buffer held
  } capture_state_t;

  // Colour by palette then shade, RGB 8:8:8
  localparam logic [23:0] palette_rgb [4][4] = '{
    '{24'hFFFFFF, 24'hAAAAAA, 24'h555555, 24'h000000},  // Gray
    '{24'hE0F8D0, 24'h88C070, 24'h346856, 24'h081820},  // DMG green
    '{24'hFFD080, 24'hC08830, 24'h704010, 24'h201000},  // Amber
    '{24'h000000, 24'h555555, 24'hAAAAAA, 24'hFFFFFF}   // Gray reversed
  };

endpackage

`default_nettype wire

// ==== button.sv ====
`timescale 1ns/10ps
`default_nettype none

module button (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic button_input,  // Raw switch, not synchronous
  output logic      pressed,       // One cycle on press
  output logic      pressed_disp   // Debounced level
);

  logic sync_q1;
  logic sync_q2;
  logic [$clog2(gb_video_pkg::debounce_cycles)-1:0] stable_cnt;  // Cycles of disagreement

  ////////////////////
  // Synchroniser
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= button_input;
      sync_q2 <= sync_q1;
    end
  end

  ////////////////////
  // Filter
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stable_cnt   <= '0;
      pressed_disp <= 1'b0;
      pressed      <= 1'b0;
    end else begin
      pressed <= 1'b0;  // Default no pulse
      if (sync_q2 == pressed_disp) begin
        stable_cnt <= '0;  // Glitch gone, start over
      end else if (int'(stable_cnt) == gb_video_pkg::debounce_cycles - 1) begin
        // Held long enough, take the new level
        stable_cnt   <= '0;
        pressed_disp <= sync_q2;
        pressed      <= sync_q2;  // Rising edge only
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== gb_lcd_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module gb_lcd_capture (
  input  wire logic                                  clk,
  input  wire logic                                  rst_n,
  input  wire logic                                  gb_hs,
  input  wire logic                                  gb_vs,
  input  wire logic                                  gb_cpl,    // Pixel latch
  input  wire logic [1:0]                            gb_pixel,
  input  wire logic                                  gb_valid,
  input  wire logic                                  freeze_toggle,
  output logic                                       wr_en,
  output logic      [gb_video_pkg::fb_addr_w-1:0]    wr_addr,
  output logic      [1:0]                            wr_shade,
  output logic                                       frozen
);

  gb_video_pkg::capture_state_t state;

  logic       hs_q, vs_q, cpl_q;  // Previous samples
  logic       hs_rise, vs_rise, cpl_rise;
  logic [7:0] lcd_col;
  logic [7:0] lcd_row;
  logic       row_started;        // First hs after vs seen
  logic       freeze_pending;
  logic       pix_ok;
  logic       in_range;

  assign hs_rise  = gb_hs & ~hs_q;
  assign vs_rise  = gb_vs & ~vs_q;
  assign cpl_rise = gb_cpl & ~cpl_q;
  assign pix_ok   = cpl_rise & gb_valid;

  // Anything past the LCD edge is dropped
  assign in_range = (int'(lcd_col) < gb_video_pkg::gb_width) &&
                    (int'(lcd_row) < gb_video_pkg::gb_height) && row_started;

  ////////////////////
  // Position tracking
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hs_q        <= 1'b0;
      vs_q        <= 1'b0;
      cpl_q       <= 1'b0;
      lcd_col     <= '0;
      lcd_row     <= '0;
      row_started <= 1'b0;
      wr_en       <= 1'b0;
    end else begin
      hs_q  <= gb_hs;
      vs_q  <= gb_vs;
      cpl_q <= gb_cpl;
      wr_en <= pix_ok && in_range && (state == gb_video_pkg::cap_active);
      if (vs_rise) begin  // New frame
        lcd_col     <= '0;
        lcd_row     <= '0;
        row_started <= 1'b0;
      end else if (hs_rise) begin
        lcd_col     <= '0;
        row_started <= 1'b1;  // First hs opens row 0
        if (row_started && int'(lcd_row) < gb_video_pkg::gb_height)
          lcd_row <= lcd_row + 1'b1;
      end else if (pix_ok && int'(lcd_col) < gb_video_pkg::gb_width) begin
        lcd_col <= lcd_col + 1'b1;  // Saturates at line end
      end
    end
  end

  // Write payload
  always_ff @(posedge clk) begin
    wr_shade <= gb_pixel;
    wr_addr  <= gb_video_pkg::fb_addr_w'(lcd_row) *
                gb_video_pkg::fb_addr_w'(gb_video_pkg::gb_width) +
                gb_video_pkg::fb_addr_w'(lcd_col);
  end

  ////////////////////
  // Freeze FSM
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= gb_video_pkg::cap_wait_frame;
      freeze_pending <= 1'b0;
    end else if (vs_rise) begin
      freeze_pending <= 1'b0;  // Request consumed at frame start
      case (state)
        gb_video_pkg::cap_wait_frame:
          state <= (freeze_pending || freeze_toggle) ? gb_video_pkg::cap_frozen
                                                     : gb_video_pkg::cap_active;
        gb_video_pkg::cap_active:
          if (freeze_pending || freeze_toggle) state <= gb_video_pkg::cap_frozen;
        gb_video_pkg::cap_frozen:
          if (freeze_pending || freeze_toggle) state <= gb_video_pkg::cap_active;
        default:
          state <= gb_video_pkg::cap_wait_frame;
      endcase
    end else if (freeze_toggle) begin
      freeze_pending <= 1'b1;  // Hold until next vsync
    end
  end

  assign frozen = (state == gb_video_pkg::cap_frozen);  // Drives led_n

endmodule

`default_nettype wire

// ==== frame_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
  input  wire logic                               clk,
  input  wire logic                               wr_en,
  input  wire logic [gb_video_pkg::fb_addr_w-1:0] wr_addr,
  input  wire logic [1:0]                         wr_shade,
  input  wire logic [gb_video_pkg::fb_addr_w-1:0] rd_addr,
  output logic      [1:0]                         rd_shade   // One cycle after rd_addr
);

  // One 2-bit shade per LCD pixel, row major
  logic [1:0] mem [gb_video_pkg::fb_depth];

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_shade;
  end

  ////////////////////
  // Read port
  ////////////////////
  always_ff @(posedge clk) begin
    rd_shade <= mem[rd_addr];  // Registered, maps to block RAM
  end

endmodule

`default_nettype wire

// ==== video_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module video_timing (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  output logic                                  hs,      // Active high
  output logic                                  vs,      // Active high
  output logic                                  active,  // Visible window
  output logic      [gb_video_pkg::h_cnt_w-1:0] x,
  output logic      [gb_video_pkg::v_cnt_w-1:0] y
);

  logic [gb_video_pkg::h_cnt_w-1:0] h_cnt;
  logic [gb_video_pkg::v_cnt_w-1:0] v_cnt;
  logic                             h_last;
  logic                             v_last;

  assign h_last = (int'(h_cnt) == gb_video_pkg::h_total - 1);
  assign v_last = (int'(v_cnt) == gb_video_pkg::v_total - 1);

  ////////////////////
  // Counters
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      if (h_last) begin
        h_cnt <= '0;
        if (v_last)
          v_cnt <= '0;  // Frame wrap
        else
          v_cnt <= v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin
    hs = (int'(h_cnt) >= gb_video_pkg::h_sync_start) &&
         (int'(h_cnt) <  gb_video_pkg::h_sync_start + gb_video_pkg::h_sync_len);
    vs = (int'(v_cnt) >= gb_video_pkg::v_sync_start) &&
         (int'(v_cnt) <  gb_video_pkg::v_sync_start + gb_video_pkg::v_sync_len);
    // Pixels only in the top left corner
    active = (int'(h_cnt) < gb_video_pkg::h_active) &&
             (int'(v_cnt) < gb_video_pkg::v_active);
  end

  assign x = h_cnt;  // Raw counters out
  assign y = v_cnt;

endmodule

`default_nettype wire

// ==== dvi_mixer.sv ====
`timescale 1ns/10ps
`default_nettype none

module dvi_mixer (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  input  wire logic                               active,
  input  wire logic                               hs,
  input  wire logic                               vs,
  input  wire logic [gb_video_pkg::h_cnt_w-1:0]   x,
  input  wire logic [gb_video_pkg::v_cnt_w-1:0]   y,
  input  wire logic [1:0]                         rd_shade,
  input  wire logic                               palette_next,  // East button pulse
  output logic      [gb_video_pkg::fb_addr_w-1:0] rd_addr,
  output logic                                    dvi_hs,
  output logic                                    dvi_vs,
  output logic                                    dvi_blank,
  output logic      [7:0]                         dvi_r,
  output logic      [7:0]                         dvi_g,
  output logic      [7:0]                         dvi_b
);

  gb_video_pkg::palette_t palette;
  gb_video_pkg::palette_t palette_succ;

  logic [gb_video_pkg::mixer_latency-1:0] hs_dly;   // Control delay line
  logic [gb_video_pkg::mixer_latency-1:0] vs_dly;
  logic [gb_video_pkg::mixer_latency-1:0] act_dly;
  logic                                   pal_pending;
  logic                                   out_vs_rise;
  logic [23:0]                            rgb;

  ////////////////////
  // Stage 1 address
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (active) begin
      // Each LCD pixel covers a 2x2 block
      rd_addr <= gb_video_pkg::fb_addr_w'(y[gb_video_pkg::v_cnt_w-1:1]) *
                 gb_video_pkg::fb_addr_w'(gb_video_pkg::gb_width) +
                 gb_video_pkg::fb_addr_w'(x[gb_video_pkg::h_cnt_w-1:1]);
    end else begin
      rd_addr <= '0;  // Keep in range during blanking
    end
  end

  // Stage 2 is the buffer read itself

  ////////////////////
  // Sync delay
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hs_dly  <= '0;
      vs_dly  <= '0;
      act_dly <= '0;
    end else begin
      hs_dly  <= {hs_dly[gb_video_pkg::mixer_latency-2:0], hs};
      vs_dly  <= {vs_dly[gb_video_pkg::mixer_latency-2:0], vs};
      act_dly <= {act_dly[gb_video_pkg::mixer_latency-2:0], active};
    end
  end

  assign dvi_hs    = hs_dly[gb_video_pkg::mixer_latency-1];
  assign dvi_vs    = vs_dly[gb_video_pkg::mixer_latency-1];
  assign dvi_blank = ~act_dly[gb_video_pkg::mixer_latency-1];
  // Next cycle dvi_vs rises
  assign out_vs_rise = vs_dly[gb_video_pkg::mixer_latency-2] &
                       ~vs_dly[gb_video_pkg::mixer_latency-1];

  ////////////////////
  // Stage 3 colour
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      rgb <= '0;
    else if (act_dly[gb_video_pkg::mixer_latency-2])
      rgb <= gb_video_pkg::palette_rgb[palette][rd_shade];
    else
      rgb <= '0;  // Black while blanked
  end

  assign dvi_r = rgb[23:16];
  assign dvi_g = rgb[15:8];
  assign dvi_b = rgb[7:0];

  // Palette order gray, green, amber, inverse
  always_comb begin
    case (palette)
      gb_video_pkg::pal_gray:    palette_succ = gb_video_pkg::pal_green;
      gb_video_pkg::pal_green:   palette_succ = gb_video_pkg::pal_amber;
      gb_video_pkg::pal_amber:   palette_succ = gb_video_pkg::pal_inverse;
      default:                   palette_succ = gb_video_pkg::pal_gray;
    endcase
  end

  // Switch only between output frames
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      palette     <= gb_video_pkg::pal_gray;
      pal_pending <= 1'b0;
    end else if (out_vs_rise) begin
      if (pal_pending || palette_next)
        palette <= palette_succ;
      pal_pending <= 1'b0;
    end else if (palette_next) begin
      pal_pending <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== gb_video_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module gb_video_top (
  input  wire logic       clk,
  input  wire logic       rst_n,     // Already debounced
  // Game Boy LCD
  input  wire logic       gb_hs,
  input  wire logic       gb_vs,
  input  wire logic       gb_cpl,
  input  wire logic [1:0] gb_pixel,
  input  wire logic       gb_valid,
  // Buttons and LEDs
  input  wire logic       sw_c,      // Freeze
  input  wire logic       sw_e,      // Palette
  output logic            led_c,
  output logic            led_e,
  output logic            led_n,     // Frozen
  // DVI
  output logic            dvi_hs,
  output logic            dvi_vs,
  output logic            dvi_blank,
  output logic      [7:0] dvi_r,
  output logic      [7:0] dvi_g,
  output logic      [7:0] dvi_b
);

  logic                               freeze_toggle;
  logic                               palette_next;
  logic                               wr_en;
  logic [gb_video_pkg::fb_addr_w-1:0] wr_addr;
  logic [1:0]                         wr_shade;
  logic [gb_video_pkg::fb_addr_w-1:0] rd_addr;
  logic [1:0]                         rd_shade;
  logic                               active;
  logic                               hs;
  logic                               vs;
  logic [gb_video_pkg::h_cnt_w-1:0]   x;
  logic [gb_video_pkg::v_cnt_w-1:0]   y;

  ////////////////////
  // Keys
  ////////////////////
  button button_c (
    .clk          (clk),
    .rst_n        (rst_n),
    .button_input (sw_c),
    .pressed      (freeze_toggle),
    .pressed_disp (led_c)
  );

  button button_e (
    .clk          (clk),
    .rst_n        (rst_n),
    .button_input (sw_e),
    .pressed      (palette_next),
    .pressed_disp (led_e)
  );

  ////////////////////
  // Capture side
  ////////////////////
  gb_lcd_capture gb_lcd_capture (
    .clk           (clk),
    .rst_n         (rst_n),
    .gb_hs         (gb_hs),
    .gb_vs         (gb_vs),
    .gb_cpl        (gb_cpl),
    .gb_pixel      (gb_pixel),
    .gb_valid      (gb_valid),
    .freeze_toggle (freeze_toggle),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_shade      (wr_shade),
    .frozen        (led_n)
  );

  frame_buffer frame_buffer (
    .clk      (clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_shade (wr_shade),
    .rd_addr  (rd_addr),
    .rd_shade (rd_shade)
  );

  ////////////////////
  // Display side
  ////////////////////
  video_timing video_timing (
    .clk    (clk),
    .rst_n  (rst_n),
    .hs     (hs),
    .vs     (vs),
    .active (active),
    .x      (x),
    .y      (y)
  );

  dvi_mixer dvi_mixer (
    .clk          (clk),
    .rst_n        (rst_n),
    .active       (active),
    .hs           (hs),
    .vs           (vs),
    .x            (x),
    .y            (y),
    .rd_shade     (rd_shade),
    .palette_next (palette_next),
    .rd_addr      (rd_addr),
    .dvi_hs       (dvi_hs),
    .dvi_vs       (dvi_vs),
    .dvi_blank    (dvi_blank),
    .dvi_r        (dvi_r),
    .dvi_g        (dvi_g),
    .dvi_b        (dvi_b)
  );

endmodule

`default_nettype wire

// ==== gb_video_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module gb_video_checker (
  input wire logic                               clk,
  input wire logic                               rst_n,
  input wire logic                               dvi_vs,
  input wire logic                               dvi_blank,
  input wire logic [7:0]                         dvi_r,
  input wire logic [7:0]                         dvi_g,
  input wire logic [7:0]                         dvi_b,
  input wire logic                               freeze_toggle,  // Centre pulse
  input wire logic                               palette_next,   // East pulse
  input wire logic                               wr_en,
  input wire logic [gb_video_pkg::fb_addr_w-1:0] wr_addr,
  input wire gb_video_pkg::capture_state_t       cap_state,
  input wire gb_video_pkg::palette_t             palette
);

  ////////////////////
  // Output side
  ////////////////////
  blank_black: assert property (@(posedge clk) disable iff (!rst_n)
    dvi_blank |-> ({dvi_r, dvi_g, dvi_b} == 24'h000000))
    else $error("rgb not black during blanking");

  // Palette moves only with the output vsync
  palette_at_vs: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(palette) |-> $rose(dvi_vs))
    else $error("palette changed away from a frame start");

  ////////////////////
  // Buttons
  ////////////////////
  freeze_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    freeze_toggle |=> !freeze_toggle)
    else $error("freeze_toggle longer than one cycle");

  palette_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    palette_next |=> !palette_next)
    else $error("palette_next longer than one cycle");

  ////////////////////
  // Capture writes
  ////////////////////
  write_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> (int'(wr_addr) < gb_video_pkg::fb_depth))
    else $error("write address beyond the buffer");

  write_not_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> (cap_state != gb_video_pkg::cap_frozen))
    else $error("buffer written while frozen");

endmodule

bind gb_video_top gb_video_checker video_checks (
  .clk           (clk),
  .rst_n         (rst_n),
  .dvi_vs        (dvi_vs),
  .dvi_blank     (dvi_blank),
  .dvi_r         (dvi_r),
  .dvi_g         (dvi_g),
  .dvi_b         (dvi_b),
  .freeze_toggle (freeze_toggle),
  .palette_next  (palette_next),
  .wr_en         (wr_en),
  .wr_addr       (wr_addr),
  .cap_state     (gb_lcd_capture.state),
  .palette       (dvi_mixer.palette)
);

`default_nettype wire

// ==== tb_gb_video_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_gb_video_top;

  // Run length budget
  localparam int lcd_frame_cycles = 4 + gb_video_pkg::gb_height * (4 + 2 * gb_video_pkg::gb_width);
  localparam int out_frame_cycles = gb_video_pkg::h_total * gb_video_pkg::v_total;
  // 3 LCD frames, 7 frame checks of up to 2 output frames each, slack for buttons
  localparam int max_cycles = 3 * lcd_frame_cycles + 14 * out_frame_cycles + 100_000;
  localparam int press_limit = 4 * gb_video_pkg::debounce_cycles;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       gb_hs;
  logic       gb_vs;
  logic       gb_cpl;
  logic [1:0] gb_pixel;
  logic       gb_valid;
  logic       sw_c;
  logic       sw_e;
  logic       led_c;
  logic       led_e;
  logic       led_n;
  logic       dvi_hs;
  logic       dvi_vs;
  logic       dvi_blank;
  logic [7:0] dvi_r;
  logic [7:0] dvi_g;
  logic [7:0] dvi_b;

  ////////////////////
  // Reference model
  ////////////////////
  logic [1:0]  exp_shade [gb_video_pkg::fb_depth];  // Expected buffer contents
  int          exp_pal        = 0;                   // 0 gray .. 3 inverse
  logic        model_frozen   = 1'b0;
  logic        freeze_pending = 1'b0;
  logic [31:0] lfsr           = 32'h90790fae;
  int          cycle_cnt      = 0;
  event        check_start;
  event        check_done;

  always #50 clk = ~clk;  // 100 ns period

  gb_video_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .gb_hs     (gb_hs),
    .gb_vs     (gb_vs),
    .gb_cpl    (gb_cpl),
    .gb_pixel  (gb_pixel),
    .gb_valid  (gb_valid),
    .sw_c      (sw_c),
    .sw_e      (sw_e),
    .led_c     (led_c),
    .led_e     (led_e),
    .led_n     (led_n),
    .dvi_hs    (dvi_hs),
    .dvi_vs    (dvi_vs),
    .dvi_blank (dvi_blank),
    .dvi_r     (dvi_r),
    .dvi_g     (dvi_g),
    .dvi_b     (dvi_b)
  );

  // Colour of one shade in one palette
  function automatic logic [23:0] expected_colour(input int pal, input logic [1:0] shade);
    return gb_video_pkg::palette_rgb[pal][shade];
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_shade(output logic [1:0] shade);
    lfsr = lfsr_step(lfsr);
    shade[1] = lfsr[0];  // One step per bit
    lfsr = lfsr_step(lfsr);
    shade[0] = lfsr[0];
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_with_error(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "%s", reason);
  endtask

  ////////////////////
  // Stimulus tasks
  ////////////////////
  task automatic send_lcd_frame;
    logic [1:0] shade;
    if (freeze_pending) begin  // Toggle lands on this vsync
      model_frozen   = ~model_frozen;
      freeze_pending = 1'b0;
    end
    @(posedge clk);
    gb_vs <= 1'b1;
    repeat (4) @(posedge clk);
    gb_vs <= 1'b0;
    for (int row = 0; row < gb_video_pkg::gb_height; row++) begin
      gb_hs <= 1'b1;  // Line start
      repeat (4) @(posedge clk);
      gb_hs <= 1'b0;
      for (int col = 0; col < gb_video_pkg::gb_width; col++) begin
        random_shade(shade);
        gb_cpl   <= 1'b1;
        gb_valid <= 1'b1;
        gb_pixel <= shade;
        @(posedge clk);
        gb_cpl <= 1'b0;  // Low half of strobe
        @(posedge clk);
        if (!model_frozen)
          exp_shade[row * gb_video_pkg::gb_width + col] = shade;
      end
    end
    gb_valid <= 1'b0;
  endtask

  // Hold a button until its LED lights, then release
  task automatic press_button(input logic east);
    int   n;
    logic lit;
    @(posedge clk);
    if (east) sw_e <= 1'b1;
    else      sw_c <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      lit = east ? led_e : led_c;
      n++;
    end while (lit !== 1'b1 && n < press_limit);
    if (lit !== 1'b1)
      stop_with_error("Button LED never lit while the button was held down");
    if (east) exp_pal = (exp_pal + 1) % 4;  // Next palette
    else      freeze_pending = 1'b1;
    @(posedge clk);
    if (east) sw_e <= 1'b0;
    else      sw_c <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      lit = east ? led_e : led_c;
      n++;
    end while (lit !== 1'b0 && n < press_limit);
    if (lit !== 1'b0)
      stop_with_error("Button LED stayed lit after the button was released");
  endtask

  task automatic glitch_east;
    @(posedge clk);
    sw_e <= 1'b1;
    repeat (gb_video_pkg::debounce_cycles / 2) @(posedge clk);  // Too short
    sw_e <= 1'b0;
    repeat (3 * gb_video_pkg::debounce_cycles) begin
      @(negedge clk);
      check_value("led_e", 32'd0, 32'(led_e));
    end
  endtask

  task automatic run_frame_check;
    -> check_start;
    @(check_done);
  endtask

  ////////////////////
  // Output compare
  ////////////////////
  always begin
    int         line;
    int         col;
    int         hpos;
    int         frame_cycles;
    int         vs_cycles;
    logic       prev_blank;
    logic       prev_vs;
    logic       frame_end;
    logic       exp_hs;
    logic [1:0] shade;
    @(check_start);
    prev_vs = dvi_vs;
    do begin  // Frame starts at dvi_vs rise
      @(negedge clk);
      frame_end = dvi_vs & ~prev_vs;
      prev_vs   = dvi_vs;
    end while (!frame_end);
    line         = 0;
    col          = 0;
    hpos         = -1;  // Line phase unknown until first active pixel
    frame_cycles = 0;
    vs_cycles    = 0;
    prev_blank   = dvi_blank;
    frame_end    = 1'b0;
    while (!frame_end) begin
      @(negedge clk);
      frame_cycles++;
      if (dvi_vs) vs_cycles++;
      // Position in the line, 0 at the first active pixel
      if (!dvi_blank && prev_blank)
        hpos = 0;
      else if (hpos >= 0)
        hpos = (hpos + 1) % gb_video_pkg::h_total;
      if (hpos >= 0) begin
        exp_hs = (hpos >= gb_video_pkg::h_sync_start) &&
                 (hpos < gb_video_pkg::h_sync_start + gb_video_pkg::h_sync_len);
        check_value("dvi_hs", 32'(exp_hs), 32'(dvi_hs));
      end
      if (!dvi_blank) begin
        if (prev_blank) col = 0;  // Blank falling opens a line
        shade = exp_shade[(line / 2) * gb_video_pkg::gb_width + col / 2];
        check_value("dvi_rgb", 32'(expected_colour(exp_pal, shade)),
                    {8'h00, dvi_r, dvi_g, dvi_b});
        col++;
      end else if (!prev_blank) begin
        check_value("active columns", gb_video_pkg::h_active, col);
        line++;
      end
      frame_end  = dvi_vs & ~prev_vs;
      prev_blank = dvi_blank;
      prev_vs    = dvi_vs;
    end
    check_value("active lines", gb_video_pkg::v_active, line);
    check_value("dvi_vs period", out_frame_cycles, frame_cycles);
    check_value("dvi_vs width", gb_video_pkg::v_sync_len * gb_video_pkg::h_total, vs_cycles);
    -> check_done;
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout: the test did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    rst_n    = 1'b0;
    gb_hs    = 1'b0;
    gb_vs    = 1'b0;
    gb_cpl   = 1'b0;
    gb_pixel = 2'b00;
    gb_valid = 1'b0;
    sw_c     = 1'b0;
    sw_e     = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("dvi_blank", 32'd1, 32'(dvi_blank));  // Reset state
    check_value("dvi_rgb", 32'd0, {8'h00, dvi_r, dvi_g, dvi_b});
    check_value("led_c", 32'd0, 32'(led_c));
    check_value("led_e", 32'd0, 32'(led_e));
    check_value("led_n", 32'd0, 32'(led_n));
    send_lcd_frame();  // First capture, gray
    run_frame_check();
    glitch_east();
    repeat (4) begin  // Green, amber, inverse, gray
      press_button(1'b1);
      run_frame_check();
    end
    press_button(1'b0);  // Freeze
    send_lcd_frame();
    check_value("led_n", 32'd1, 32'(led_n));
    run_frame_check();
    press_button(1'b0);  // Unfreeze
    send_lcd_frame();
    check_value("led_n", 32'd0, 32'(led_n));
    run_frame_check();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
gb_video_pkg.sv
button.sv
gb_lcd_capture.sv
frame_buffer.sv
video_timing.sv
dvi_mixer.sv
gb_video_top.sv
gb_video_checker.sv
tb_gb_video_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_gb_video_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -Mdir $(OBJ_DIR)

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status is nonzero when the testbench hits $fatal
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
